// File: logic/fu_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module fu_pipe #(
    parameter type payload_t = logic [7:0],
    parameter int  latency   = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     busy,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic [latency-1:0] stage_valid;
    payload_t           stage_data [latency];
    logic [latency-1:0] move;  // stage i may load this cycle

    // free slots ripple back from the output end
    always_comb begin
        move[latency-1] = !stage_valid[latency-1] || out_ready;
        for (int i = latency - 2; i >= 0; i--) begin
            move[i] = !stage_valid[i] || move[i+1];
        end
    end

    assign busy      = !move[0];
    assign out_valid = stage_valid[latency-1];
    assign out_data  = stage_data[latency-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else begin
            if (move[0]) begin
                stage_valid[0] <= in_valid;
            end
            for (int i = 1; i < latency; i++) begin
                if (move[i]) begin
                    stage_valid[i] <= stage_valid[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (move[0]) begin
            stage_data[0] <= in_data;
        end
        for (int i = 1; i < latency; i++) begin
            if (move[i]) begin
                stage_data[i] <= stage_data[i-1];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/issue_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module issue_buffer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  warp_issue_pkg::instr_t in_instr,
    output logic                   in_ready,
    issue_if.buffer                issue
);

    logic                   full;
    warp_issue_pkg::instr_t held;
    logic                   issue_fire;

    assign issue_fire  = full && !issue.stall;
    assign in_ready    = !full || issue_fire;  // refill in the cycle it leaves
    assign issue.valid = full;
    assign issue.instr = held;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (issue_fire) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held <= in_instr;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        (issue.valid && issue.stall) |=> (issue.valid && $stable(issue.instr)));

endmodule

`default_nettype wire

// File: logic/issue_ifs.sv
`timescale 1ns/1ps
`default_nettype none

interface issue_if;

    logic                    valid;
    warp_issue_pkg::instr_t  instr;
    logic                    stall;  // from the scoreboard, same cycle

    modport buffer (
        output valid,
        output instr,
        input  stall
    );

    modport scoreboard (
        input  valid,
        input  instr,
        output stall
    );

    // functional unit side, qualified by is_mem at the top level
    modport sink (
        input valid,
        input instr,
        input stall
    );

endinterface

interface wb_if;

    logic               valid;
    warp_issue_pkg::wb_t wb;

    modport source (
        output valid,
        output wb
    );

    modport sink (
        input valid,
        input wb
    );

endinterface

`default_nettype wire

// File: logic/warp_issue_pkg.sv
`default_nettype none

package warp_issue_pkg;

    localparam int num_warps   = 4;
    localparam int num_threads = 4;
    localparam int num_regs    = 32;  // r0 is hardwired, never tracked

    localparam int warp_w = $clog2(num_warps);
    localparam int reg_w  = $clog2(num_regs);
    localparam int tag_w  = 8;

    typedef logic [num_threads-1:0] thread_mask_t;

    typedef struct packed {
        logic [warp_w-1:0] warp;
        logic [reg_w-1:0]  rd;
        logic [reg_w-1:0]  rs1;
        logic [reg_w-1:0]  rs2;
        logic              uses_rs2;
        logic              writes_rd;
        logic              is_mem;   // else exec
        thread_mask_t      mask;
        logic [tag_w-1:0]  tag;
    } instr_t;

    typedef struct packed {
        logic [warp_w-1:0] warp;
        logic [reg_w-1:0]  rd;
        logic              writes_rd;
        thread_mask_t      mask;     // threads finished by this writeback
        logic [tag_w-1:0]  tag;
    } wb_t;

endpackage

`default_nettype wire

// File: logic/warp_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module warp_issue_top #(
    parameter int exec_latency = 2,
    parameter int mem_latency  = 4
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   in_valid,
    input  logic [warp_issue_pkg::warp_w-1:0]      in_warp,
    input  logic [warp_issue_pkg::reg_w-1:0]       in_rd,
    input  logic [warp_issue_pkg::reg_w-1:0]       in_rs1,
    input  logic [warp_issue_pkg::reg_w-1:0]       in_rs2,
    input  logic                                   in_uses_rs2,
    input  logic                                   in_writes_rd,
    input  logic                                   in_is_mem,
    input  logic [warp_issue_pkg::num_threads-1:0] in_mask,
    input  logic [warp_issue_pkg::tag_w-1:0]       in_tag,
    output logic                                   in_ready,
    output logic                                   wb_valid,
    output logic [warp_issue_pkg::warp_w-1:0]      wb_warp,
    output logic [warp_issue_pkg::reg_w-1:0]       wb_rd,
    output logic [warp_issue_pkg::num_threads-1:0] wb_mask,
    output logic [warp_issue_pkg::tag_w-1:0]       wb_tag,
    output logic                                   idle
);

    issue_if issue_bus ();
    wb_if    wb_bus ();

    warp_issue_pkg::instr_t in_instr;
    warp_issue_pkg::wb_t    issue_wb;
    warp_issue_pkg::wb_t    exec_out;
    warp_issue_pkg::wb_t    mem_out;
    logic issue_fire;
    logic mem_busy;
    logic exec_out_valid;
    logic exec_out_ready;
    logic mem_out_valid;
    logic mem_out_ready;

    assign in_instr = '{warp: in_warp, rd: in_rd, rs1: in_rs1, rs2: in_rs2,
                        uses_rs2: in_uses_rs2, writes_rd: in_writes_rd,
                        is_mem: in_is_mem, mask: in_mask, tag: in_tag};

    assign issue_fire = issue_bus.valid && !issue_bus.stall;
    assign issue_wb   = '{warp: issue_bus.instr.warp, rd: issue_bus.instr.rd,
                          writes_rd: issue_bus.instr.writes_rd,
                          mask: issue_bus.instr.mask, tag: issue_bus.instr.tag};

    issue_buffer u_buffer (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_ready (in_ready),
        .issue    (issue_bus.buffer)
    );

    warp_scoreboard u_scoreboard (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue_bus.scoreboard),
        .wb       (wb_bus.sink),
        .mem_busy (mem_busy),
        .idle     (idle)
    );

    fu_pipe #(.payload_t(warp_issue_pkg::wb_t), .latency(exec_latency)) exec_pipe (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (issue_fire && !issue_bus.instr.is_mem),
        .in_data   (issue_wb),
        .busy      (),
        .out_valid (exec_out_valid),
        .out_data  (exec_out),
        .out_ready (exec_out_ready)
    );

    fu_pipe #(.payload_t(warp_issue_pkg::wb_t), .latency(mem_latency)) mem_pipe (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (issue_fire && issue_bus.instr.is_mem),
        .in_data   (issue_wb),
        .busy      (mem_busy),
        .out_valid (mem_out_valid),
        .out_data  (mem_out),
        .out_ready (mem_out_ready)
    );

    wb_arbiter u_arbiter (
        .exec_valid (exec_out_valid),
        .exec_data  (exec_out),
        .exec_ready (exec_out_ready),
        .mem_valid  (mem_out_valid),
        .mem_data   (mem_out),
        .mem_ready  (mem_out_ready),
        .wb         (wb_bus.source)
    );

    assign wb_valid = wb_bus.valid;
    assign wb_warp  = wb_bus.wb.warp;
    assign wb_rd    = wb_bus.wb.rd;
    assign wb_mask  = wb_bus.wb.mask;
    assign wb_tag   = wb_bus.wb.tag;

endmodule

`default_nettype wire

// File: logic/warp_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module warp_scoreboard (
    input  logic        clk,
    input  logic        reset,
    issue_if.scoreboard issue,
    wb_if.sink          wb,
    input  logic        mem_busy,
    output logic        idle
);

    localparam int nw    = warp_issue_pkg::num_warps;
    localparam int nr    = warp_issue_pkg::num_regs;
    localparam int cnt_w = $clog2(nw * nr) + 1;

    warp_issue_pkg::thread_mask_t pend_mask [nw][nr];  // threads still owing a write
    logic [cnt_w-1:0]             outstanding;

    warp_issue_pkg::instr_t       ins;
    warp_issue_pkg::wb_t          wbr;
    warp_issue_pkg::thread_mask_t wb_cur;
    warp_issue_pkg::thread_mask_t wb_left;
    logic rs1_hit;
    logic rs2_hit;
    logic rd_hit;
    logic pending_hit;
    logic issue_fire;
    logic issue_set;
    logic wb_apply;
    logic wb_done;

    assign ins = issue.instr;
    assign wbr = wb.wb;

    assign rs1_hit = (ins.rs1 != '0) && (pend_mask[ins.warp][ins.rs1] != '0);
    assign rs2_hit = ins.uses_rs2 && (ins.rs2 != '0) && (pend_mask[ins.warp][ins.rs2] != '0);
    assign rd_hit  = (ins.rd != '0) && (pend_mask[ins.warp][ins.rd] != '0);  // WAW
    assign pending_hit = rs1_hit || rs2_hit || rd_hit;

    assign issue.stall = issue.valid && (pending_hit || (ins.is_mem && mem_busy));

    assign issue_fire = issue.valid && !issue.stall;
    assign issue_set  = issue_fire && ins.writes_rd && (ins.rd != '0) && (ins.mask != '0);

    assign wb_apply = wb.valid && wbr.writes_rd && (wbr.rd != '0) && (wbr.mask != '0);
    assign wb_cur   = pend_mask[wbr.warp][wbr.rd];
    assign wb_left  = wb_cur & ~wbr.mask;
    assign wb_done  = wb_apply && (wb_cur != '0) && (wb_left == '0);  // last thread retired

    assign idle = (outstanding == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < nw; w++) begin
                for (int r = 0; r < nr; r++) begin
                    pend_mask[w][r] <= '0;
                end
            end
            outstanding <= '0;
        end else begin
            if (wb_apply) begin
                pend_mask[wbr.warp][wbr.rd] <= wb_left;
            end
            if (issue_set) begin
                pend_mask[ins.warp][ins.rd] <= ins.mask;  // issue wins over a same-cycle wb
            end

            if (issue_set && !wb_done) begin
                outstanding <= outstanding + 1'b1;
            end else if (wb_done && !issue_set) begin
                outstanding <= outstanding - 1'b1;
            end
        end
    end

    // a writeback has to belong to an instruction that was issued earlier
    a_wb_pending: assert property (@(posedge clk) disable iff (reset)
        wb_apply |-> (wb_cur != '0));

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        (wb_done && !issue_set) |-> (outstanding != '0));

endmodule

`default_nettype wire

// File: logic/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  logic                exec_valid,
    input  warp_issue_pkg::wb_t exec_data,
    output logic                exec_ready,
    input  logic                mem_valid,
    input  warp_issue_pkg::wb_t mem_data,
    output logic                mem_ready,
    wb_if.source                wb
);

    logic exec_grant;
    logic mem_grant;

    assign exec_ready = 1'b1;         // exec never waits
    assign mem_ready  = !exec_valid;  // memory takes leftover slots

    assign exec_grant = exec_valid && exec_ready;
    assign mem_grant  = mem_valid && mem_ready;

    assign wb.valid = exec_grant || mem_grant;
    assign wb.wb    = exec_grant ? exec_data : mem_data;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module warp_issue_tb -f warp_issue.f \
    --Mdir obj_dir -o warp_issue_sim

output=$(./obj_dir/warp_issue_sim)
echo "$output"
if ! grep -qF '** PASS **' <<< "$output"; then
    exit 1
fi

// File: tests/warp_issue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module warp_issue_tb;

    localparam int max_entries    = 64;
    localparam int timeout_cycles = 400;

    logic                                   clk;
    logic                                   reset;
    logic                                   in_valid;
    logic [warp_issue_pkg::warp_w-1:0]      in_warp;
    logic [warp_issue_pkg::reg_w-1:0]       in_rd, in_rs1, in_rs2;
    logic                                   in_uses_rs2, in_writes_rd, in_is_mem;
    logic [warp_issue_pkg::num_threads-1:0] in_mask;
    logic [warp_issue_pkg::tag_w-1:0]       in_tag;
    logic                                   in_ready, wb_valid, idle;
    logic [warp_issue_pkg::warp_w-1:0]      wb_warp;
    logic [warp_issue_pkg::reg_w-1:0]       wb_rd;
    logic [warp_issue_pkg::num_threads-1:0] wb_mask;
    logic [warp_issue_pkg::tag_w-1:0]       wb_tag;

    warp_issue_pkg::instr_t tbl [max_entries];  // tag equals table index
    int producer [max_entries];
    int arrival  [max_entries];                  // writeback order, -1 until seen
    int n_entries, wb_count, error_count, seed;
    bit timed_out, seen_busy;

    warp_issue_top #(.exec_latency(2), .mem_latency(4)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic add_entry(input int w, input int rd, input int rs1, input int rs2,
                             input int u2, input int wr, input int mem, input int m);
        warp_issue_pkg::instr_t e;
        e.warp      = w[warp_issue_pkg::warp_w-1:0];
        e.rd        = rd[warp_issue_pkg::reg_w-1:0];
        e.rs1       = rs1[warp_issue_pkg::reg_w-1:0];
        e.rs2       = rs2[warp_issue_pkg::reg_w-1:0];
        e.uses_rs2  = u2[0];
        e.writes_rd = wr[0];
        e.is_mem    = mem[0];
        e.mask      = m[warp_issue_pkg::num_threads-1:0];
        e.tag       = n_entries[warp_issue_pkg::tag_w-1:0];
        tbl[n_entries] = e;
        n_entries++;
    endtask

    // latest earlier entry on the same warp whose rd this one reads or overwrites
    function automatic int find_producer(input int i);
        int p;
        p = -1;
        for (int j = 0; j < i; j++) begin
            if (tbl[j].warp == tbl[i].warp && tbl[j].writes_rd && tbl[j].rd != 0 &&
                (tbl[j].rd == tbl[i].rs1 || tbl[j].rd == tbl[i].rd ||
                 (tbl[i].uses_rs2 && tbl[j].rd == tbl[i].rs2))) begin
                p = j;
            end
        end
        return p;
    endfunction

    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("ERROR at %0t: %s got %0h expected %0h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!in_ready && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!in_ready) begin
            $display("timeout: in_ready stayed low while offering tag %0d", in_tag);
            timed_out = 1'b1;
            error_count++;
        end
    endtask

    // writeback monitor, sampled away from the driving edge
    always @(negedge clk) begin
        int t;
        if (!reset) begin
            if (!idle) begin
                seen_busy = 1'b1;
            end
            if (wb_valid) begin
                t = int'(wb_tag);
                if (t >= n_entries) begin
                    $display("ERROR at %0t: unknown tag %0d written back", $time, t);
                    error_count++;
                end else begin
                    if (arrival[t] >= 0) begin
                        $display("ERROR at %0t: tag %0d written back twice", $time, t);
                        error_count++;
                    end
                    arrival[t] = wb_count;
                    check_value("wb_warp", wb_warp, tbl[t].warp);
                    check_value("wb_rd", wb_rd, tbl[t].rd);
                    check_value("wb_mask", wb_mask, tbl[t].mask);
                end
                wb_count++;
            end
        end
    end

    initial begin
        int r;
        int n;
        seed         = 5448;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_warp      = '0;
        in_rd        = '0;
        in_rs1       = '0;
        in_rs2       = '0;
        in_uses_rs2  = 1'b0;
        in_writes_rd = 1'b0;
        in_is_mem    = 1'b0;
        in_mask      = '0;
        in_tag       = '0;
        n_entries    = 0;
        wb_count     = 0;
        error_count  = 0;
        timed_out    = 1'b0;
        seen_busy    = 1'b0;
        for (int i = 0; i < max_entries; i++) begin
            arrival[i] = -1;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("idle", idle, 1);
        check_value("in_ready", in_ready, 1);
        check_value("wb_valid", wb_valid, 0);

        // warp, rd, rs1, rs2, uses_rs2, writes_rd, is_mem, mask
        add_entry(0, 1, 0, 0, 0, 1, 0, 'hf);
        add_entry(0, 2, 1, 0, 0, 1, 0, 'hf);   // RAW on r1
        add_entry(0, 2, 3, 0, 0, 1, 1, 'h3);   // WAW on r2 through memory
        add_entry(0, 4, 2, 1, 1, 1, 1, 'hf);   // reads both
        add_entry(1, 1, 0, 0, 0, 1, 0, 'hf);   // same reg, other warp
        add_entry(0, 0, 0, 0, 0, 1, 0, 'h5);   // r0 write is not tracked
        add_entry(0, 5, 0, 0, 1, 1, 0, 'hf);
        add_entry(2, 3, 0, 0, 0, 1, 1, 'h5);
        add_entry(3, 3, 0, 0, 0, 1, 0, 'ha);
        add_entry(2, 6, 3, 0, 0, 1, 0, 'hf);   // waits on a memory result
        add_entry(1, 7, 0, 0, 0, 1, 1, 'h1);   // memory burst fills the mem pipe
        add_entry(1, 8, 0, 0, 0, 1, 1, 'h2);
        add_entry(1, 9, 0, 0, 0, 1, 1, 'h4);
        add_entry(1, 10, 0, 0, 0, 1, 1, 'h8);
        add_entry(3, 11, 0, 0, 0, 1, 0, 'hf);  // exec collides with memory results
        add_entry(2, 12, 0, 0, 0, 1, 0, 'hf);
        add_entry(0, 0, 4, 0, 0, 0, 0, 'hf);   // store-like, no rd write
        add_entry(1, 7, 8, 10, 1, 1, 0, 'h3);
        // random part, r0..r3 of two warps so hazards are frequent
        repeat (40) begin
            r = $random(seed);
            add_entry(r[0], r[2:1], r[4:3], r[6:5], r[7], r[9:8] != 0, r[10], r[14:11] | 1);
        end
        for (int i = 0; i < n_entries; i++) begin
            producer[i] = find_producer(i);
        end

        @(posedge clk);
        for (int i = 0; i < n_entries && !timed_out; i++) begin
            in_valid     <= 1'b1;
            in_warp      <= tbl[i].warp;
            in_rd        <= tbl[i].rd;
            in_rs1       <= tbl[i].rs1;
            in_rs2       <= tbl[i].rs2;
            in_uses_rs2  <= tbl[i].uses_rs2;
            in_writes_rd <= tbl[i].writes_rd;
            in_is_mem    <= tbl[i].is_mem;
            in_mask      <= tbl[i].mask;
            in_tag       <= tbl[i].tag;
            wait_ready();
            @(posedge clk);
        end
        in_valid <= 1'b0;

        if (!timed_out) begin
            n = 0;
            @(negedge clk);
            while ((wb_count < n_entries || !idle) && n < timeout_cycles) begin
                @(negedge clk);
                n++;
            end
            if (wb_count < n_entries || !idle) begin
                $display("timeout: %0d of %0d writebacks seen, idle is %0b",
                         wb_count, n_entries, idle);
                error_count++;
            end
        end

        for (int i = 0; i < n_entries; i++) begin
            if (arrival[i] < 0) begin
                $display("ERROR: tag %0d was never written back", i);
                error_count++;
            end else if (producer[i] >= 0 && arrival[i] <= arrival[producer[i]]) begin
                $display("ERROR: tag %0d written back before its producer tag %0d",
                         i, producer[i]);
                error_count++;
            end
        end
        if (!seen_busy) begin
            $display("ERROR: idle never dropped while registers were outstanding");
            error_count++;
        end
        $display("entries %0d, writebacks %0d, errors %0d", n_entries, wb_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: warp_issue.f
logic/warp_issue_pkg.sv
logic/issue_ifs.sv
logic/warp_scoreboard.sv
logic/issue_buffer.sv
logic/fu_pipe.sv
logic/wb_arbiter.sv
logic/warp_issue_top.sv
tests/warp_issue_tb.sv
